// File: logic/kicker_rom_pkg.sv
package kicker_rom_pkg;

    // SDRAM geometry
    localparam int sdram_aw = 22;    // Word address
    localparam int sdram_dw = 16;

    // Download port byte address
    localparam int ioctl_aw = 25;

    // Read slots: scroll, sprites, main CPU
    localparam int slot_count = 3;

    // Slot payloads
    typedef logic [31:0] word32_t;   // Two SDRAM words, first word in the low half
    typedef logic [7:0]  byte_t;

    // Where a download byte belongs
    typedef enum logic [1:0] {
        region_main = 2'd0,
        region_scr  = 2'd1,
        region_obj  = 2'd2,
        region_prom = 2'd3
    } region_t;

endpackage

// File: logic/rom_dwnld_decode.sv
`timescale 1ns/1ps

module rom_dwnld_decode #(
    parameter logic [kicker_rom_pkg::ioctl_aw-1:0] scr_start  = 25'h10000,
    parameter logic [kicker_rom_pkg::ioctl_aw-1:0] obj_start  = 25'h14000,
    parameter logic [kicker_rom_pkg::ioctl_aw-1:0] prom_start = 25'h1C000
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                downloading,
    input  logic [kicker_rom_pkg::ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    input  logic                                ioctl_wr,
    input  logic                                sdram_ack,
    output logic [kicker_rom_pkg::sdram_aw-1:0] prog_addr,
    output logic [kicker_rom_pkg::sdram_dw-1:0] prog_data,
    output logic [1:0]                          prog_mask,    // Active low byte enables
    output logic                                prog_we,
    output logic                                prom_we
);
    import kicker_rom_pkg::*;

    region_t             region;
    logic                byte_wr;
    logic [ioctl_aw-2:0] word_addr;
    logic [ioctl_aw-2:0] swz_addr;
    logic [ioctl_aw-1:0] prom_offset;

    assign byte_wr     = ioctl_wr && downloading;
    assign word_addr   = ioctl_addr[ioctl_aw-1:1];
    assign prom_offset = ioctl_addr - prom_start;    // PROMs are byte wide

    always_comb begin
        if (ioctl_addr < scr_start)       region = region_main;
        else if (ioctl_addr < obj_start)  region = region_scr;
        else if (ioctl_addr < prom_start) region = region_obj;
        else                              region = region_prom;
    end

    // Reorder tile and sprite words so that a 32-bit fetch gets both halves of a row
    always_comb begin
        swz_addr = word_addr;
        case (region)
            region_scr: begin
                swz_addr[0]   = ~word_addr[3];
                swz_addr[3:1] = word_addr[2:0];
            end
            region_obj: begin
                swz_addr[0]   = ~word_addr[3];
                swz_addr[1]   = ~word_addr[4];
                swz_addr[5:2] = {word_addr[5], word_addr[2:0]};
            end
            default: ;    // Main and PROM addresses pass unchanged
        endcase
    end

    always_ff @(posedge clk) begin
        if (byte_wr) begin
            if (region == region_prom) prog_addr <= prom_offset[sdram_aw-1:0];
            else                       prog_addr <= swz_addr[sdram_aw-1:0];
            prog_data <= {2{ioctl_dout}};                 // Same byte on both lanes
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;   // Odd bytes go to the upper lane
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;    // Single cycle strobe
            if (byte_wr) begin
                if (region == region_prom) prom_we <= 1'b1;
                else                       prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

endmodule

// File: logic/rom_slot_buffer.sv
`timescale 1ns/1ps

module rom_slot_buffer #(
    parameter type data_t = kicker_rom_pkg::word32_t,
    parameter int  aw     = 14
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cs,
    input  logic [aw-1:0]           addr,
    input  logic                    fill,
    input  kicker_rom_pkg::word32_t fill_data,
    output data_t                   data,
    output logic                    ok,
    output logic                    pend
);

    logic          valid;
    logic          hit;
    logic          stale;      // Address moved while the fetch was in flight
    logic          discard;
    logic [aw-1:0] req_addr;   // Address being fetched
    logic [aw-1:0] cached_addr;
    data_t         cached_data;
    data_t         fill_payload;

    assign hit     = valid && (addr == cached_addr);
    assign ok      = hit && cs;
    assign data    = cached_data;
    assign discard = stale || (addr != req_addr);

    // Byte slots pick their lane from the byte address, wide slots take the pair
    always_comb begin
        if ($bits(data_t) == 8)
            fill_payload = data_t'(req_addr[0] ? fill_data[15:8] : fill_data[7:0]);
        else
            fill_payload = data_t'(fill_data);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            pend  <= 1'b0;
            stale <= 1'b0;
        end else if (pend) begin
            if (fill) begin
                pend  <= 1'b0;
                stale <= 1'b0;
                if (!discard) valid <= 1'b1;
            end else if (addr != req_addr) begin
                stale <= 1'b1;
            end
        end else if (cs && !hit) begin
            pend <= 1'b1;    // Miss
        end
    end

    always_ff @(posedge clk) begin
        if (!pend && cs && !hit)
            req_addr <= addr;
        if (pend && fill && !discard) begin
            cached_addr <= req_addr;
            cached_data <= fill_payload;
        end
    end

endmodule

// File: logic/rom_slot_arbiter.sv
`timescale 1ns/1ps

module rom_slot_arbiter #(
    parameter logic [kicker_rom_pkg::ioctl_aw-1:0] scr_start = 25'h10000,
    parameter logic [kicker_rom_pkg::ioctl_aw-1:0] obj_start = 25'h14000
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  downloading,
    input  logic [kicker_rom_pkg::slot_count-1:0] pend,
    input  logic [13:0]                           scr_addr,
    input  logic [14:0]                           obj_addr,
    input  logic [15:0]                           main_addr,    // Byte address
    input  logic                                  sdram_ack,
    input  logic                                  data_dst,
    input  logic                                  data_rdy,
    input  logic [kicker_rom_pkg::sdram_dw-1:0]   data_read,
    output logic                                  sdram_req,
    output logic [kicker_rom_pkg::sdram_aw-1:0]   sdram_addr,
    output logic [kicker_rom_pkg::slot_count-1:0] fill,
    output kicker_rom_pkg::word32_t               fill_data
);
    import kicker_rom_pkg::*;

    localparam int sel_w = $clog2(slot_count);

    // Byte offsets turned into word offsets
    localparam logic [sdram_aw-1:0] scr_offset = scr_start[sdram_aw:1];
    localparam logic [sdram_aw-1:0] obj_offset = obj_start[sdram_aw:1];

    typedef enum logic [1:0] {
        st_idle,
        st_req,     // Waiting for sdram_ack
        st_data     // Waiting for the second word
    } state_t;

    state_t              state;
    logic [sel_w-1:0]    sel;
    logic [sel_w-1:0]    next_sel;
    logic [sdram_aw-1:0] slot_addr;
    logic [sdram_dw-1:0] low_word;

    // Lowest pending slot wins
    always_comb begin
        next_sel = '0;
        for (int i = slot_count - 1; i >= 0; i--) begin
            if (pend[i]) next_sel = sel_w'(i);
        end
    end

    // Wide slots take two words per entry
    always_comb begin
        case (next_sel)
            2'd0:    slot_addr = scr_offset + sdram_aw'({scr_addr, 1'b0});
            2'd1:    slot_addr = obj_offset + sdram_aw'({obj_addr, 1'b0});
            default: slot_addr = sdram_aw'(main_addr[15:1]);
        endcase
    end

    assign fill_data = {data_read, low_word};

    always_comb begin
        fill = '0;
        if (state == st_data && data_rdy) fill[sel] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                st_idle: if (!downloading && |pend) begin
                    state     <= st_req;
                    sdram_req <= 1'b1;
                end
                st_req: if (sdram_ack) begin
                    state     <= st_data;
                    sdram_req <= 1'b0;
                end
                st_data: if (data_rdy) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            sel        <= next_sel;    // Frozen once the request goes out
            sdram_addr <= slot_addr;
        end
        if (data_dst && state != st_idle)
            low_word <= data_read;
    end

endmodule

// File: logic/kicker_rom_top.sv
`timescale 1ns/1ps

module kicker_rom_top #(
    parameter logic [kicker_rom_pkg::ioctl_aw-1:0] scr_start  = 25'h10000,
    parameter logic [kicker_rom_pkg::ioctl_aw-1:0] obj_start  = 25'h14000,
    parameter logic [kicker_rom_pkg::ioctl_aw-1:0] prom_start = 25'h1C000
) (
    input  logic                                clk,
    input  logic                                reset,
    // ROM download
    input  logic                                downloading,
    input  logic [kicker_rom_pkg::ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    input  logic                                ioctl_wr,
    output logic [kicker_rom_pkg::sdram_aw-1:0] prog_addr,
    output logic [kicker_rom_pkg::sdram_dw-1:0] prog_data,
    output logic [1:0]                          prog_mask,
    output logic                                prog_we,
    output logic                                prom_we,
    // SDRAM read port
    output logic                                sdram_req,
    output logic [kicker_rom_pkg::sdram_aw-1:0] sdram_addr,
    input  logic                                sdram_ack,
    input  logic                                data_dst,
    input  logic                                data_rdy,
    input  logic [kicker_rom_pkg::sdram_dw-1:0] data_read,
    // Scroll tiles
    input  logic                                scr_cs,
    input  logic [13:0]                         scr_addr,
    output kicker_rom_pkg::word32_t             scr_data,
    output logic                                scr_ok,
    // Sprites
    input  logic                                obj_cs,
    input  logic [14:0]                         obj_addr,
    output kicker_rom_pkg::word32_t             obj_data,
    output logic                                obj_ok,
    // Main CPU
    input  logic                                main_cs,
    input  logic [15:0]                         main_addr,
    output kicker_rom_pkg::byte_t               main_data,
    output logic                                main_ok
);
    import kicker_rom_pkg::*;

    logic [slot_count-1:0] pend;
    logic [slot_count-1:0] fill;
    word32_t               fill_data;

    rom_dwnld_decode #(
        .scr_start  ( scr_start  ),
        .obj_start  ( obj_start  ),
        .prom_start ( prom_start )
    ) u_decode (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    rom_slot_buffer #(.data_t(word32_t), .aw(14)) u_scr (
        .clk(clk), .reset(reset), .cs(scr_cs), .addr(scr_addr), .fill(fill[0]),
        .fill_data(fill_data), .data(scr_data), .ok(scr_ok), .pend(pend[0])
    );

    rom_slot_buffer #(.data_t(word32_t), .aw(15)) u_obj (
        .clk(clk), .reset(reset), .cs(obj_cs), .addr(obj_addr), .fill(fill[1]),
        .fill_data(fill_data), .data(obj_data), .ok(obj_ok), .pend(pend[1])
    );

    rom_slot_buffer #(.data_t(byte_t), .aw(16)) u_main (
        .clk(clk), .reset(reset), .cs(main_cs), .addr(main_addr), .fill(fill[2]),
        .fill_data(fill_data), .data(main_data), .ok(main_ok), .pend(pend[2])
    );

    rom_slot_arbiter #(
        .scr_start ( scr_start ),
        .obj_start ( obj_start )
    ) u_arbiter (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .pend        ( pend        ),
        .scr_addr    ( scr_addr    ),
        .obj_addr    ( obj_addr    ),
        .main_addr   ( main_addr   ),
        .sdram_ack   ( sdram_ack   ),
        .data_dst    ( data_dst    ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .fill        ( fill        ),
        .fill_data   ( fill_data   )
    );

endmodule

// File: verif/sdram_model.sv
`timescale 1ns/1ps

module sdram_model (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [kicker_rom_pkg::sdram_aw-1:0] prog_addr,
    input  logic [kicker_rom_pkg::sdram_dw-1:0] prog_data,
    input  logic [1:0]                          prog_mask,
    input  logic                                prog_we,
    input  logic                                sdram_req,
    input  logic [kicker_rom_pkg::sdram_aw-1:0] sdram_addr,
    output logic                                sdram_ack = 1'b0,
    output logic                                data_dst  = 1'b0,
    output logic                                data_rdy  = 1'b0,
    output logic [kicker_rom_pkg::sdram_dw-1:0] data_read = '0
);

    typedef enum logic [1:0] {ph_idle, ph_wait, ph_first, ph_second} phase_t;

    logic [15:0] mem [0:65535];    // Low 64K words only
    phase_t      phase;
    logic        is_wr;
    logic [2:0]  cnt;
    logic [15:0] addr;
    logic [31:0] rng = 32'd26756;
    logic [31:0] rng_next;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] fill_word(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ 16'h6b2d;
    endfunction

    assign rng_next = xorshift(rng);

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 65536; i++)
                mem[i] = fill_word(16'(i));
            phase     <= ph_idle;
            sdram_ack <= 1'b0;
            data_dst  <= 1'b0;
            data_rdy  <= 1'b0;
        end else begin
            sdram_ack <= 1'b0;
            data_dst  <= 1'b0;
            data_rdy  <= 1'b0;
            case (phase)
                ph_idle: if (prog_we || sdram_req) begin
                    is_wr <= prog_we;    // Writes first
                    addr  <= prog_we ? prog_addr[15:0] : sdram_addr[15:0];
                    cnt   <= 3'd1 + 3'(rng_next[1:0]);    // 1 to 4 cycles
                    rng   <= rng_next;
                    phase <= ph_wait;
                end
                ph_wait: if (cnt == 3'd1) begin
                    sdram_ack <= 1'b1;
                    if (is_wr && !prog_mask[0]) mem[addr][7:0] = prog_data[7:0];
                    if (is_wr && !prog_mask[1]) mem[addr][15:8] = prog_data[15:8];
                    phase <= ph_first;
                end else begin
                    cnt <= cnt - 3'd1;
                end
                // Also the gap that lets the DUT drop its request
                ph_first: if (is_wr) begin
                    phase <= ph_idle;
                end else begin
                    data_dst  <= 1'b1;
                    data_read <= mem[addr];
                    phase     <= ph_second;
                end
                ph_second: begin
                    data_rdy  <= 1'b1;
                    data_read <= mem[addr + 16'd1];
                    phase     <= ph_idle;
                end
            endcase
        end
    end

endmodule

// File: verif/kicker_rom_tb.sv
`timescale 1ns/1ps

module kicker_rom_tb;
    import kicker_rom_pkg::*;

    localparam logic [ioctl_aw-1:0] scr_start  = 25'h10000;
    localparam logic [ioctl_aw-1:0] obj_start  = 25'h14000;
    localparam logic [ioctl_aw-1:0] prom_start = 25'h1C000;

    // Read table, slot 0 scroll, 1 sprite, 2 main; address; hit expected
    localparam int          n_reads = 13;
    localparam int          read_slot [n_reads] = '{2, 2, 2, 2, 0, 0, 0, 0, 1, 1, 1, 1, 2};
    localparam logic [15:0] read_addr [n_reads] = '{
        16'h0000, 16'h0001, 16'h0013, 16'h0013, 16'd0, 16'd5, 16'd15,
        16'd15, 16'd0, 16'd7, 16'd31, 16'd31, 16'h001e};
    localparam logic        read_hit  [n_reads] = '{0, 0, 0, 1, 0, 0, 0, 1, 0, 0, 0, 1, 0};

    logic                clk         = 1'b0;
    logic                reset       = 1'b1;
    logic                downloading = 1'b0;
    logic [ioctl_aw-1:0] ioctl_addr  = '0;
    logic [7:0]          ioctl_dout  = '0;
    logic                ioctl_wr    = 1'b0;
    logic [sdram_aw-1:0] prog_addr;
    logic [sdram_dw-1:0] prog_data;
    logic [1:0]          prog_mask;
    logic                prog_we;
    logic                prom_we;
    logic                sdram_req;
    logic [sdram_aw-1:0] sdram_addr;
    logic                sdram_ack;
    logic                data_dst;
    logic                data_rdy;
    logic [sdram_dw-1:0] data_read;
    logic                scr_cs   = 1'b0;
    logic [13:0]         scr_addr = '0;
    word32_t             scr_data;
    logic                scr_ok;
    logic                obj_cs   = 1'b0;
    logic [14:0]         obj_addr = '0;
    word32_t             obj_data;
    logic                obj_ok;
    logic                main_cs   = 1'b0;
    logic [15:0]         main_addr = '0;
    byte_t               main_data;
    logic                main_ok;
    logic [15:0]         exp_mem [0:65535];    // Expected SDRAM contents

    kicker_rom_top #(
        .scr_start  ( scr_start  ),
        .obj_start  ( obj_start  ),
        .prom_start ( prom_start )
    ) i_dut (.*);

    sdram_model u_sdram (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] fill_word(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ 16'h6b2d;
    endfunction

    function automatic logic [7:0] image_byte(input logic [ioctl_aw-1:0] a);
        return a[7:0] ^ a[15:8] ^ {a[16:14], 5'h15};
    endfunction

    function automatic region_t region_of(input logic [ioctl_aw-1:0] a);
        if (a < scr_start) return region_main;
        if (a < obj_start) return region_scr;
        if (a < prom_start) return region_obj;
        return region_prom;
    endfunction

    function automatic logic [15:0] swizzle(input logic [23:0] w, input region_t r);
        if (r == region_scr) return 16'({w[23:4], w[2:0], ~w[3]});
        if (r == region_obj) return 16'({w[23:6], w[5], w[2:0], ~w[4], ~w[3]});
        return w[15:0];
    endfunction

    // Main bytes come back as downloaded, wide slots read two swizzled words
    function automatic logic [31:0] expected_read(input int s, input logic [15:0] a);
        logic [15:0] w;
        if (s == 2) return 32'(image_byte(ioctl_aw'(a)));
        w = 16'(((s == 0) ? scr_start : obj_start) >> 1) + 16'(a << 1);
        return {exp_mem[w + 16'd1], exp_mem[w]};
    endfunction

    function automatic logic slot_ok(input int s);
        case (s)
            0:       return scr_ok;
            1:       return obj_ok;
            default: return main_ok;
        endcase
    endfunction

    function automatic logic [31:0] slot_data(input int s);
        case (s)
            0:       return scr_data;
            1:       return obj_data;
            default: return {24'h0, main_data};
        endcase
    endfunction

    function automatic string slot_name(input int s);
        case (s)
            0:       return "scr_data";
            1:       return "obj_data";
            default: return "main_data";
        endcase
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stop_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic download_byte(input logic [ioctl_aw-1:0] a);
        int          t;
        logic [15:0] sw;
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_dout <= image_byte(a);
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(negedge clk);
        if (region_of(a) == region_prom) begin
            assert (prom_we && !prog_we) else stop_run("PROM byte did not pulse prom_we alone");
            check_value("prog_addr", 32'(prog_addr), 32'(a - prom_start));
            check_value("prog_data", 32'(prog_data[7:0]), 32'(image_byte(a)));
            @(negedge clk);
            assert (!prom_we) else stop_run("prom_we stayed high for more than one cycle");
        end else begin
            sw = swizzle(24'(a >> 1), region_of(a));
            if (a[0]) exp_mem[sw][15:8] = image_byte(a);
            else      exp_mem[sw][7:0]  = image_byte(a);
            assert (prog_we) else stop_run("ROM byte did not raise prog_we");
            t = 0;
            while (prog_we) begin
                assert (t < 20) else stop_run("timeout waiting for prog_we to drop");
                t++;
                @(negedge clk);
            end
        end
    endtask

    task automatic download_range(input logic [ioctl_aw-1:0] start, input int count);
        for (int i = 0; i < count; i++)
            download_byte(start + ioctl_aw'(i));
    endtask

    task automatic drive_slot(input int s, input logic [15:0] a, input logic cs);
        case (s)
            0: begin
                scr_cs   <= cs;
                scr_addr <= a[13:0];
            end
            1: begin
                obj_cs   <= cs;
                obj_addr <= a[14:0];
            end
            default: begin
                main_cs   <= cs;
                main_addr <= a;
            end
        endcase
    endtask

    task automatic wait_ok(input int s);
        int t;
        t = 0;
        while (!slot_ok(s)) begin
            assert (t < 200) else stop_run($sformatf("timeout waiting for ok on %s", slot_name(s)));
            t++;
            @(negedge clk);
        end
    endtask

    task automatic read_entry(input int s, input logic [15:0] a, input logic hit);
        @(posedge clk);
        drive_slot(s, a, 1'b1);
        @(negedge clk);
        if (hit) begin
            assert (slot_ok(s)) else stop_run("repeated address did not hit in the same cycle");
            repeat (3) begin
                assert (!sdram_req) else stop_run("a cache hit started an SDRAM read");
                @(negedge clk);
            end
        end
        wait_ok(s);
        check_value(slot_name(s), slot_data(s), expected_read(s, a));
        @(posedge clk);
        drive_slot(s, a, 1'b0);
    endtask

    initial begin
        logic [15:0] w;
        for (int i = 0; i < 65536; i++)
            exp_mem[i] = fill_word(16'(i));
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        downloading <= 1'b1;
        download_range('0, 32);
        download_range(scr_start, 64);     // Two whole scroll swizzle blocks
        download_range(obj_start, 128);    // Two whole sprite swizzle blocks
        download_range(prom_start, 8);
        @(posedge clk);
        downloading <= 1'b0;
        @(negedge clk);
        // PROM bytes land neither on their own words nor on the words at their offsets
        for (int i = 0; i < 8; i++) begin
            w = 16'(prom_start >> 1) + 16'(i);
            check_value("sdram mem", 32'(u_sdram.mem[w]), 32'(fill_word(w)));
            check_value("sdram mem", 32'(u_sdram.mem[i]), 32'(exp_mem[i]));
        end
        for (int i = 0; i < n_reads; i++)
            read_entry(read_slot[i], read_addr[i], read_hit[i]);
        // All three slots miss together
        for (int r = 0; r < 3; r++) begin
            @(posedge clk);
            drive_slot(0, 16'(3 + 4 * r), 1'b1);
            drive_slot(1, 16'(2 + 9 * r), 1'b1);
            drive_slot(2, 16'(5 + 7 * r), 1'b1);
            @(negedge clk);
            for (int s = 0; s < 3; s++)
                wait_ok(s);
            check_value("scr_data", scr_data, expected_read(0, 16'(3 + 4 * r)));
            check_value("obj_data", obj_data, expected_read(1, 16'(2 + 9 * r)));
            check_value("main_data", 32'(main_data), expected_read(2, 16'(5 + 7 * r)));
            @(posedge clk);
            for (int s = 0; s < 3; s++)
                drive_slot(s, 16'h0, 1'b0);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: tb.f
logic/kicker_rom_pkg.sv
logic/rom_dwnld_decode.sv
logic/rom_slot_buffer.sv
logic/rom_slot_arbiter.sv
logic/kicker_rom_top.sv
verif/sdram_model.sv
verif/kicker_rom_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the ROM subsystem testbench with Verilator and run it
# A $fatal in the testbench gives a non-zero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module kicker_rom_tb -o kicker_rom_sim
./obj_dir/kicker_rom_sim
